//--- hw/sram_fifo_defines.svh
`ifndef SRAM_FIFO_DEFINES_SVH
`define SRAM_FIFO_DEFINES_SVH

`define SF_DATA_W           32           // source word width
`define SF_SRAM_AW          20           // external SRAM address bits
`define SF_SRAM_DEPTH       (1 << 20)    // ring size in halfwords
`define SF_BUF_DEPTH        16           // words in front buffer

`define SF_VERSION          2
`define SF_ALMOST_FULL_PCT  95           // percent of ring
`define SF_ALMOST_EMPTY_PCT 5            // percent of ring

`endif

//--- hw/sram_fifo_pkg.sv
package sram_fifo_pkg;

    // read side of the SRAM ring
    typedef enum logic [1:0] {
        READ_FETCH = 2'd0,   // SRAM output enabled, halfword captured
        READ_HOLD  = 2'd2,   // staged halfword shown on USB
        READ_TRY   = 2'd3    // nothing staged, wait for data
    } read_state_e;

    typedef enum logic [2:0] {
        REG_CTRL         = 3'd0,
        REG_ALMOST_FULL  = 3'd1,
        REG_ALMOST_EMPTY = 3'd2,
        REG_READ_ERR     = 3'd3,
        REG_SIZE_0       = 3'd4,
        REG_SIZE_1       = 3'd5,
        REG_SIZE_2       = 3'd6,
        REG_RSVD         = 3'd7
    } reg_addr_e;

endpackage

//--- hw/fifo_status_if.sv
`timescale 1ns/1ns
`include "sram_fifo_defines.svh"

interface fifo_status_if;

    logic [`SF_SRAM_AW:0] size;          // halfwords held, staging included
    logic                 empty;         // nothing left for the USB side
    logic                 full;          // SRAM ring cannot take a halfword
    logic [7:0]           read_err_cnt;  // reads seen while empty

    modport ctrl (
        output size,
        output empty,
        output full,
        output read_err_cnt
    );

    modport regs (
        input size,
        input empty,
        input full,
        input read_err_cnt
    );

endinterface

//--- hw/word_buffer_fifo.sv
`timescale 1ns/1ns
`include "sram_fifo_defines.svh"

module word_buffer_fifo #(
    parameter int DATA_W = `SF_DATA_W,
    parameter int DEPTH  = `SF_BUF_DEPTH
) (
    input  logic              BUS_CLK,
    input  logic              RST,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic [DATA_W-1:0] pop_data,
    output logic              full,
    output logic              empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge BUS_CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push and pop together
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];  // head word, fall-through
    assign full     = (count == (PTR_W + 1)'(DEPTH));
    assign empty    = (count == '0);

endmodule

//--- hw/sram_fifo_regs.sv
`timescale 1ns/1ns
`include "sram_fifo_defines.svh"

module sram_fifo_regs
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH = `SF_SRAM_DEPTH
) (
    input  logic                BUS_CLK,
    input  logic                BUS_RST,
    input  logic [15:0]         BUS_ADD,
    input  logic [7:0]          BUS_DATA_IN,
    input  logic                BUS_RD,
    input  logic                BUS_WR,
    output logic [7:0]          BUS_DATA_OUT,
    output logic                RST,
    fifo_status_if.regs         status,
    output logic                FIFO_NEAR_FULL,
    output logic                FIFO_READ_ERROR
);

    localparam logic [7:0] AF_DEFAULT = 8'(255 * `SF_ALMOST_FULL_PCT / 100);
    localparam logic [7:0] AE_DEFAULT = 8'(255 * `SF_ALMOST_EMPTY_PCT / 100);

    reg_addr_e   addr;
    logic        addr_hit;        // upper address bits all zero
    logic [7:0]  almost_full;
    logic [7:0]  almost_empty;
    logic [21:0] size_byte;
    logic [21:0] size_byte_latch;
    logic [29:0] full_prod;
    logic [29:0] empty_prod;
    logic [21:0] full_lvl;
    logic [21:0] empty_lvl;

    assign addr      = reg_addr_e'(BUS_ADD[2:0]);
    assign addr_hit  = (BUS_ADD[15:3] == '0);
    assign RST       = BUS_RST || (BUS_WR && addr_hit && addr == REG_CTRL);  // soft reset
    assign size_byte = {status.size, 1'b0};

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            almost_full  <= AF_DEFAULT;
            almost_empty <= AE_DEFAULT;
        end else if (BUS_WR && addr_hit) begin
            if (addr == REG_ALMOST_FULL)
                almost_full <= BUS_DATA_IN;
            if (addr == REG_ALMOST_EMPTY)
                almost_empty <= BUS_DATA_IN;
        end
    end

    // low byte read snapshots the whole count
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RD && addr_hit && addr == REG_SIZE_0)
            size_byte_latch <= size_byte;
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RD) begin
            if (!addr_hit) begin
                BUS_DATA_OUT <= 8'h00;
            end else begin
                case (addr)
                    REG_CTRL:         BUS_DATA_OUT <= 8'(`SF_VERSION);
                    REG_ALMOST_FULL:  BUS_DATA_OUT <= almost_full;
                    REG_ALMOST_EMPTY: BUS_DATA_OUT <= almost_empty;
                    REG_READ_ERR:     BUS_DATA_OUT <= status.read_err_cnt;
                    REG_SIZE_0:       BUS_DATA_OUT <= size_byte[7:0];
                    REG_SIZE_1:       BUS_DATA_OUT <= size_byte_latch[15:8];
                    REG_SIZE_2:       BUS_DATA_OUT <= {2'b00, size_byte_latch[21:16]};
                    default:          BUS_DATA_OUT <= 8'h00;   // reserved
                endcase
            end
        end
    end

    // thresholds scaled to the ring, in halfwords
    assign full_prod  = (30'(almost_full) + 30'd1) * 30'(DEPTH);
    assign empty_prod = (30'(almost_empty) + 30'd1) * 30'(DEPTH);
    assign full_lvl   = full_prod[29:8];
    assign empty_lvl  = empty_prod[29:8];

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            FIFO_NEAR_FULL <= 1'b0;
        else if ({1'b0, status.size} >= full_lvl)
            FIFO_NEAR_FULL <= 1'b1;
        else if ({1'b0, status.size} <= empty_lvl || status.size == '0)
            FIFO_NEAR_FULL <= 1'b0;   // hysteresis band keeps last value
    end

    assign FIFO_READ_ERROR = (status.read_err_cnt != 8'h00);

endmodule

//--- hw/sram_fifo_ctrl.sv
`timescale 1ns/1ns
`include "sram_fifo_defines.svh"

module sram_fifo_ctrl
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH = `SF_SRAM_DEPTH
) (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  logic [`SF_DATA_W-1:0]  buf_data,
    input  logic                   buf_empty,
    output logic                   buf_pop,
    output logic [`SF_SRAM_AW-1:0] SRAM_A,
    inout  wire  [15:0]            SRAM_IO,
    output logic                   SRAM_OE_B,
    output logic                   SRAM_WE_B,
    input  logic                   USB_READ,
    output logic [7:0]             USB_DATA,
    fifo_status_if.ctrl            status
);

    localparam int AW = `SF_SRAM_AW;

    read_state_e    read_state;
    read_state_e    read_state_next;
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW-1:0]  wr_ptr_next;
    logic [AW-1:0]  rd_ptr_next;
    logic           sram_empty;
    logic           sram_full;
    logic           fetch;
    logic           write_sram;
    logic [15:0]    wr_half;
    logic [15:0]    stage_data;     // halfword shown to USB
    logic           byte_sel;       // 0 low byte, 1 high byte
    logic [AW:0]    fill;
    logic [7:0]     err_cnt;

    assign wr_ptr_next = (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_next = (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    assign sram_empty  = (wr_ptr == rd_ptr);
    assign sram_full   = (wr_ptr_next == rd_ptr);   // one slot stays free

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            read_state <= READ_TRY;
        else
            read_state <= read_state_next;
    end

    always_comb begin
        read_state_next = read_state;
        case (read_state)
            READ_TRY:
                if (!sram_empty)
                    read_state_next = READ_FETCH;
            READ_FETCH:
                read_state_next = READ_HOLD;
            READ_HOLD:
                if (USB_READ && byte_sel)    // second byte consumed
                    read_state_next = sram_empty ? READ_TRY : READ_FETCH;
            default:
                read_state_next = READ_TRY;
        endcase
    end

    assign fetch = (read_state == READ_FETCH);

    // write side yields the bus to fetches
    assign write_sram = !buf_empty && !sram_full && !fetch;
    assign buf_pop    = write_sram && wr_ptr[0];  // high half done
    assign wr_half    = wr_ptr[0] ? buf_data[31:16] : buf_data[15:0];

    assign SRAM_A    = fetch ? rd_ptr : wr_ptr;
    assign SRAM_IO   = write_sram ? wr_half : 16'hzzzz;
    assign SRAM_WE_B = !write_sram;
    assign SRAM_OE_B = !fetch;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write_sram)
                wr_ptr <= wr_ptr_next;
            if (fetch)
                rd_ptr <= rd_ptr_next;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (fetch)
            stage_data <= SRAM_IO;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            byte_sel <= 1'b0;
        else if (fetch)
            byte_sel <= 1'b0;
        else if (USB_READ && read_state == READ_HOLD)
            byte_sel <= !byte_sel;
    end

    assign USB_DATA = byte_sel ? stage_data[15:8] : stage_data[7:0];

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            err_cnt <= 8'h00;
        else if (USB_READ && status.empty && err_cnt != 8'hff)
            err_cnt <= err_cnt + 1'b1;   // saturates at 255
    end

    assign fill = (wr_ptr >= rd_ptr) ? {1'b0, wr_ptr} - {1'b0, rd_ptr}
                                     : {1'b0, wr_ptr} + (AW + 1)'(DEPTH) - {1'b0, rd_ptr};

    assign status.size         = fill + (AW + 1)'(read_state == READ_HOLD);
    assign status.empty        = sram_empty && (read_state != READ_HOLD);
    assign status.full         = sram_full;
    assign status.read_err_cnt = err_cnt;

endmodule

//--- hw/sram_fifo.sv
`timescale 1ns/1ns
`include "sram_fifo_defines.svh"

module sram_fifo #(
    parameter int SRAM_DEPTH = `SF_SRAM_DEPTH
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic [15:0]            BUS_ADD,
    input  logic [7:0]             BUS_DATA_IN,
    input  logic                   BUS_RD,
    input  logic                   BUS_WR,
    output logic [7:0]             BUS_DATA_OUT,

    output logic [`SF_SRAM_AW-1:0] SRAM_A,
    inout  wire  [15:0]            SRAM_IO,
    output logic                   SRAM_BHE_B,
    output logic                   SRAM_BLE_B,
    output logic                   SRAM_CE1_B,
    output logic                   SRAM_OE_B,
    output logic                   SRAM_WE_B,

    input  logic                   USB_READ,
    output logic [7:0]             USB_DATA,

    output logic                   FIFO_READ_NEXT_OUT,
    input  logic                   FIFO_EMPTY_IN,
    input  logic [`SF_DATA_W-1:0]  FIFO_DATA,

    output logic                   FIFO_NOT_EMPTY,
    output logic                   FIFO_FULL,
    output logic                   FIFO_NEAR_FULL,
    output logic                   FIFO_READ_ERROR
);

    logic                  RST;        // bus reset or soft reset
    logic                  buf_full;
    logic                  buf_empty;
    logic                  buf_pop;
    logic [`SF_DATA_W-1:0] buf_data;

    fifo_status_if u_status ();

    assign FIFO_READ_NEXT_OUT = !buf_full;       // back-pressure to source
    assign SRAM_BHE_B         = 1'b0;            // both byte lanes always on
    assign SRAM_BLE_B         = 1'b0;
    assign SRAM_CE1_B         = 1'b0;
    assign FIFO_NOT_EMPTY     = !u_status.empty;
    assign FIFO_FULL          = u_status.full;

    word_buffer_fifo #(
        .DATA_W (`SF_DATA_W),
        .DEPTH  (`SF_BUF_DEPTH)
    ) u_buf (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .push      (!FIFO_EMPTY_IN && !buf_full),
        .push_data (FIFO_DATA),
        .pop       (buf_pop),
        .pop_data  (buf_data),
        .full      (buf_full),
        .empty     (buf_empty)
    );

    sram_fifo_ctrl #(
        .DEPTH (SRAM_DEPTH)
    ) u_ctrl (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .buf_data  (buf_data),
        .buf_empty (buf_empty),
        .buf_pop   (buf_pop),
        .SRAM_A    (SRAM_A),
        .SRAM_IO   (SRAM_IO),
        .SRAM_OE_B (SRAM_OE_B),
        .SRAM_WE_B (SRAM_WE_B),
        .USB_READ  (USB_READ),
        .USB_DATA  (USB_DATA),
        .status    (u_status)
    );

    sram_fifo_regs #(
        .DEPTH (SRAM_DEPTH)
    ) u_regs (
        .BUS_CLK         (BUS_CLK),
        .BUS_RST         (BUS_RST),
        .BUS_ADD         (BUS_ADD),
        .BUS_DATA_IN     (BUS_DATA_IN),
        .BUS_RD          (BUS_RD),
        .BUS_WR          (BUS_WR),
        .BUS_DATA_OUT    (BUS_DATA_OUT),
        .RST             (RST),
        .status          (u_status),
        .FIFO_NEAR_FULL  (FIFO_NEAR_FULL),
        .FIFO_READ_ERROR (FIFO_READ_ERROR)
    );

endmodule

//--- dv/sram_model.sv
`timescale 1ns/1ns

module sram_model #(
    parameter int AW    = 20,
    parameter int DEPTH = 64
) (
    input  logic          clk,     // write lands at the end of the strobe cycle
    input  logic [AW-1:0] addr,
    inout  wire  [15:0]   io,
    input  logic          ce_b,
    input  logic          oe_b,
    input  logic          we_b,
    input  logic          bhe_b,
    input  logic          ble_b
);

    localparam int IW = $clog2(DEPTH);

    logic [15:0] mem [DEPTH];

    assign io = (!ce_b && !oe_b && we_b) ? mem[addr[IW-1:0]] : 16'hzzzz;

    always_ff @(posedge clk) begin
        if (!ce_b && !we_b) begin
            if (!ble_b)
                mem[addr[IW-1:0]][7:0] <= io[7:0];
            if (!bhe_b)
                mem[addr[IW-1:0]][15:8] <= io[15:8];
        end
    end

endmodule

//--- dv/sram_fifo_assert.sv
`timescale 1ns/1ns
`include "sram_fifo_defines.svh"

module sram_fifo_assert
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input logic                   BUS_CLK,
    input logic                   RST,
    input read_state_e            read_state,
    input logic                   write_sram,
    input logic                   SRAM_WE_B,
    input logic                   SRAM_OE_B,
    input logic [`SF_SRAM_AW-1:0] wr_ptr,
    input logic [`SF_SRAM_AW-1:0] rd_ptr,
    input logic [7:0]             err_cnt
);

    assert property (@(posedge BUS_CLK) disable iff (RST) !(!SRAM_WE_B && !SRAM_OE_B))
        else $error("SRAM write strobe and output enable low together");

    // SRAM owns the data bus while a fetch is on
    assert property (@(posedge BUS_CLK) disable iff (RST)
        (read_state == READ_FETCH) |-> !write_sram)
        else $error("controller drives the SRAM bus during a fetch");

    assert property (@(posedge BUS_CLK) disable iff (RST)
        (32'(wr_ptr) < DEPTH) && (32'(rd_ptr) < DEPTH))
        else $error("ring pointer out of range");

    // a soft reset may clear a saturated count
    assert property (@(posedge BUS_CLK) disable iff (RST)
        ((err_cnt == 8'hff) && !RST) |=> (err_cnt == 8'hff))
        else $error("read error count wrapped");

endmodule

bind sram_fifo_ctrl sram_fifo_assert #(.DEPTH(DEPTH)) u_assert (
    .BUS_CLK    (BUS_CLK),
    .RST        (RST),
    .read_state (read_state),
    .write_sram (write_sram),
    .SRAM_WE_B  (SRAM_WE_B),
    .SRAM_OE_B  (SRAM_OE_B),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr),
    .err_cnt    (err_cnt)
);

//--- dv/tb_sram_fifo.sv
`timescale 1ns/1ns
`include "sram_fifo_defines.svh"

module tb_sram_fifo;
    import sram_fifo_pkg::*;

    localparam int TBL_LEN  = 8;
    localparam int DEPTH    = 64;                          // ring size in halfwords
    localparam int HOLD_MAX = DEPTH / 2 + `SF_BUF_DEPTH;   // 63 in ring, 1 staged, buffer
    localparam int WATCHDOG = TBL_LEN * 200 + 5000;

    // word, then its bytes in USB order
    localparam logic [63:0] STIM [TBL_LEN] = '{
        64'h12345678_78563412,
        64'hdeadbeef_efbeadde,
        64'h00000001_01000000,
        64'hffff0000_0000ffff,
        64'ha5c3e1f0_f0e1c3a5,
        64'h80000000_00000080,
        64'h0badcafe_fecaad0b,
        64'h13579bdf_df9b5713
    };

    logic                   BUS_CLK;
    logic                   BUS_RST;
    logic [15:0]            BUS_ADD;
    logic [7:0]             BUS_DATA_IN;
    logic                   BUS_RD;
    logic                   BUS_WR;
    logic [7:0]             BUS_DATA_OUT;
    logic [`SF_SRAM_AW-1:0] SRAM_A;
    wire  [15:0]            SRAM_IO;
    logic                   SRAM_BHE_B;
    logic                   SRAM_BLE_B;
    logic                   SRAM_CE1_B;
    logic                   SRAM_OE_B;
    logic                   SRAM_WE_B;
    logic                   USB_READ;
    logic [7:0]             USB_DATA;
    logic                   FIFO_READ_NEXT_OUT;
    logic                   FIFO_EMPTY_IN;
    logic [`SF_DATA_W-1:0]  FIFO_DATA;
    logic                   FIFO_NOT_EMPTY;
    logic                   FIFO_FULL;
    logic                   FIFO_NEAR_FULL;
    logic                   FIFO_READ_ERROR;

    int         errors = 0;
    logic [7:0] exp_q[$];   // bytes still owed by the USB side

    sram_fifo #(.SRAM_DEPTH(DEPTH)) u_dut (.*);

    sram_model #(.AW(`SF_SRAM_AW), .DEPTH(DEPTH)) u_sram (
        .clk   (BUS_CLK),
        .addr  (SRAM_A),
        .io    (SRAM_IO),
        .ce_b  (SRAM_CE1_B),
        .oe_b  (SRAM_OE_B),
        .we_b  (SRAM_WE_B),
        .bhe_b (SRAM_BHE_B),
        .ble_b (SRAM_BLE_B)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #10 BUS_CLK = ~BUS_CLK;
    end

    initial begin
        repeat (WATCHDOG) @(posedge BUS_CLK);
        $display("Timeout: the run did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [21:0] got,
                               input logic [21:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%06h, expected 0x%06h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got != exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= 16'(addr);
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR      <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= 16'(addr);
        BUS_RD  <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD  <= 1'b0;
        @(negedge BUS_CLK);
        data = BUS_DATA_OUT;
    endtask

    task automatic read_byte_count(output logic [21:0] cnt);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        reg_read(REG_SIZE_0, b0);   // latches the upper bytes
        reg_read(REG_SIZE_1, b1);
        reg_read(REG_SIZE_2, b2);
        cnt = {b2[5:0], b1, b0};
    endtask

    // the write side settles in a variable number of cycles
    task automatic wait_byte_count(input logic [21:0] target);
        logic [21:0] cnt;
        int          tries;
        tries = 0;
        read_byte_count(cnt);
        while (cnt != target && tries < 40) begin
            read_byte_count(cnt);
            tries++;
        end
        check_count("byte count", cnt, target);
    endtask

    task automatic send_word(input int idx, input bit stop_when_full, output bit taken);
        bit done;
        int k;
        done  = 1'b0;
        taken = 1'b0;
        repeat ($urandom_range(2)) @(posedge BUS_CLK);   // source gap
        @(posedge BUS_CLK);
        FIFO_DATA     <= STIM[idx][63:32];
        FIFO_EMPTY_IN <= 1'b0;
        while (!done) begin
            @(negedge BUS_CLK);
            if (FIFO_READ_NEXT_OUT) begin
                taken = 1'b1;
                done  = 1'b1;
            end else if (stop_when_full && FIFO_FULL) begin
                done = 1'b1;   // ring and buffer both full
            end
        end
        @(posedge BUS_CLK);
        FIFO_EMPTY_IN <= 1'b1;
        if (taken) begin
            for (k = 0; k < 4; k++)
                exp_q.push_back(STIM[idx][31 - 8 * k -: 8]);
        end
    endtask

    task automatic pulse_read();
        @(posedge BUS_CLK);
        USB_READ <= 1'b1;
        @(posedge BUS_CLK);
        USB_READ <= 1'b0;
    endtask

    task automatic empty_read();
        pulse_read();
        repeat (3) @(posedge BUS_CLK);
    endtask

    task automatic read_check_byte();
        logic [7:0] got;
        @(negedge BUS_CLK);
        while (!FIFO_NOT_EMPTY)
            @(negedge BUS_CLK);
        repeat (3) @(posedge BUS_CLK);   // byte valid 3 cycles on
        @(negedge BUS_CLK);
        got = USB_DATA;
        if (exp_q.size() == 0) begin
            $display("Error: a byte was read but none was expected");
            errors++;
        end else begin
            check_byte("USB_DATA", got, exp_q.pop_front());
        end
        pulse_read();
    endtask

    task automatic drain(input int n);
        repeat (n) read_check_byte();
    endtask

    initial begin
        logic [7:0]  rd;
        logic [21:0] cnt;
        bit          taken;
        int          n;
        void'($urandom(40975));
        BUS_RST       = 1'b1;
        BUS_ADD       = '0;
        BUS_DATA_IN   = '0;
        BUS_RD        = 1'b0;
        BUS_WR        = 1'b0;
        USB_READ      = 1'b0;
        FIFO_EMPTY_IN = 1'b1;
        FIFO_DATA     = '0;
        repeat (2) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;

        reg_read(REG_CTRL, rd);
        check_byte("REG_CTRL", rd, 8'd2);
        reg_read(REG_ALMOST_FULL, rd);
        check_byte("REG_ALMOST_FULL", rd, 8'd242);
        reg_read(REG_ALMOST_EMPTY, rd);
        check_byte("REG_ALMOST_EMPTY", rd, 8'd12);
        reg_read(REG_READ_ERR, rd);
        check_byte("REG_READ_ERR", rd, 8'd0);
        check_flag("FIFO_NOT_EMPTY", FIFO_NOT_EMPTY, 1'b0);
        check_flag("FIFO_FULL", FIFO_FULL, 1'b0);
        check_flag("FIFO_NEAR_FULL", FIFO_NEAR_FULL, 1'b0);
        check_flag("FIFO_READ_ERROR", FIFO_READ_ERROR, 1'b0);

        for (n = 0; n < TBL_LEN; n++)
            send_word(n, 1'b0, taken);
        wait_byte_count(22'(4 * TBL_LEN));
        drain(4 * TBL_LEN);
        @(negedge BUS_CLK);
        check_flag("FIFO_NOT_EMPTY", FIFO_NOT_EMPTY, 1'b0);

        repeat (3) empty_read();
        reg_read(REG_READ_ERR, rd);
        check_byte("REG_READ_ERR", rd, 8'd3);
        check_flag("FIFO_READ_ERROR", FIFO_READ_ERROR, 1'b1);
        repeat (260) empty_read();   // past saturation
        reg_read(REG_READ_ERR, rd);
        check_byte("REG_READ_ERR", rd, 8'hff);

        // near-full set at 32 halfwords, clear at 8
        reg_write(REG_ALMOST_FULL, 8'd127);
        reg_write(REG_ALMOST_EMPTY, 8'd31);
        for (n = 0; n < 16; n++)
            send_word(n % TBL_LEN, 1'b0, taken);
        wait_byte_count(22'd64);
        check_flag("FIFO_NEAR_FULL", FIFO_NEAR_FULL, 1'b1);
        drain(40);
        wait_byte_count(22'd24);
        check_flag("FIFO_NEAR_FULL", FIFO_NEAR_FULL, 1'b1);   // inside the band
        drain(8);
        wait_byte_count(22'd16);
        check_flag("FIFO_NEAR_FULL", FIFO_NEAR_FULL, 1'b0);
        drain(16);

        n     = 0;
        taken = 1'b1;
        while (taken && n < 2 * HOLD_MAX) begin
            send_word(n % TBL_LEN, 1'b1, taken);
            if (taken)
                n++;
        end
        check_count("words accepted", 22'(n), 22'(HOLD_MAX));
        check_flag("FIFO_FULL", FIFO_FULL, 1'b1);
        check_flag("FIFO_READ_NEXT_OUT", FIFO_READ_NEXT_OUT, 1'b0);
        read_byte_count(cnt);
        check_count("byte count", cnt, 22'(2 * DEPTH));
        drain(4 * n);
        @(negedge BUS_CLK);
        check_flag("FIFO_NOT_EMPTY", FIFO_NOT_EMPTY, 1'b0);

        // enough to raise near-full before the soft reset
        for (n = 0; n < 16; n++)
            send_word(n % TBL_LEN, 1'b0, taken);
        wait_byte_count(22'd64);
        reg_write(REG_CTRL, 8'h00);   // soft reset
        exp_q.delete();
        read_byte_count(cnt);
        check_count("byte count", cnt, 22'd0);
        reg_read(REG_READ_ERR, rd);
        check_byte("REG_READ_ERR", rd, 8'd0);
        reg_read(REG_ALMOST_FULL, rd);
        check_byte("REG_ALMOST_FULL", rd, 8'd242);
        reg_read(REG_ALMOST_EMPTY, rd);
        check_byte("REG_ALMOST_EMPTY", rd, 8'd12);
        check_flag("FIFO_NOT_EMPTY", FIFO_NOT_EMPTY, 1'b0);
        check_flag("FIFO_READ_ERROR", FIFO_READ_ERROR, 1'b0);
        check_flag("FIFO_NEAR_FULL", FIFO_NEAR_FULL, 1'b0);

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/sram_fifo_pkg.sv
hw/fifo_status_if.sv
hw/word_buffer_fifo.sv
hw/sram_fifo_regs.sv
hw/sram_fifo_ctrl.sv
hw/sram_fifo.sv
dv/sram_model.sv
dv/sram_fifo_assert.sv
dv/tb_sram_fifo.sv

//--- Makefile
SIM := obj_dir/Vtb_sram_fifo

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): build.f hw/*.sv hw/*.svh dv/*.sv
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_sram_fifo

# a crashed or aborted simulation counts as a failure too
run: $(SIM)
	$(SIM) > sim.log 2>&1 || echo "Something failed" >> sim.log
	cat sim.log
	! grep -q "Something failed" sim.log

clean:
	rm -rf obj_dir sim.log
